/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -j 0 --top-module lpcWindowTb -f list.f -o simv
	out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* common/acfCtrlPkg.sv */
package acfCtrlPkg;

	// Sequencer phases
	typedef enum logic [1:0] {
		// Collecting a frame
		sLoad,
		// Products of one lag
		sAccum,
		// Two cycles for the MAC pipeline
		sDrain,
		// Result handed out
		sEmit
	} seqState_t;

	// Accumulator opcodes, valid with the operands on the same cycle
	typedef enum logic [1:0] {
		opIdle,
		opClear,
		opAccum,
		opEmit
	} macOp_t;

endpackage

/* common/lpcPkg.sv */
package lpcPkg;

	// Frame and lag geometry
	localparam int frameLen = 240;
	localparam int numLags = 11;

	// Datapath widths
	localparam int sampleW = 16;
	localparam int acfW = 40;
	localparam int idxW = 8;
	localparam int lagW = 4;

	//////////////////////////////////////////////////////////////////////
	// Asymmetric analysis window, unsigned Q15
	// Rising half-Hamming over the first 200 taps, quarter cosine after
	//////////////////////////////////////////////////////////////////////
	localparam logic [sampleW-1:0] hammingWindow [frameLen] = '{
		2621, 2623, 2629, 2638, 2651, 2668, 2689, 2713, 2741, 2772,
		2808, 2847, 2890, 2936, 2986, 3040, 3097, 3158, 3223, 3291,
		3363, 3438, 3517, 3599, 3685, 3774, 3867, 3963, 4063, 4166,
		4272, 4382, 4495, 4611, 4731, 4853, 4979, 5108, 5240, 5376,
		5514, 5655, 5800, 5947, 6097, 6250, 6406, 6565, 6726, 6890,
		7057, 7227, 7399, 7573, 7750, 7930, 8112, 8296, 8483, 8672,
		8863, 9057, 9252, 9450, 9650, 9852, 10055, 10261, 10468, 10677,
		10888, 11101, 11315, 11531, 11748, 11967, 12187, 12409, 12632, 12856,
		13082, 13308, 13536, 13764, 13994, 14225, 14456, 14688, 14921, 15155,
		15389, 15624, 15859, 16095, 16331, 16568, 16805, 17042, 17279, 17516,
		17754, 17991, 18228, 18465, 18702, 18939, 19175, 19411, 19647, 19882,
		20117, 20350, 20584, 20816, 21048, 21279, 21509, 21738, 21967, 22194,
		22420, 22644, 22868, 23090, 23311, 23531, 23749, 23965, 24181, 24394,
		24606, 24816, 25024, 25231, 25435, 25638, 25839, 26037, 26234, 26428,
		26621, 26811, 26999, 27184, 27368, 27548, 27727, 27903, 28076, 28247,
		28415, 28581, 28743, 28903, 29061, 29215, 29367, 29515, 29661, 29804,
		29944, 30081, 30214, 30345, 30472, 30597, 30718, 30836, 30950, 31062,
		31170, 31274, 31376, 31474, 31568, 31659, 31747, 31831, 31911, 31988,
		32062, 32132, 32198, 32261, 32320, 32376, 32428, 32476, 32521, 32561,
		32599, 32632, 32662, 32688, 32711, 32729, 32744, 32755, 32763, 32767,
		// Peak, then the cosine tail
		32767, 32741, 32665, 32537, 32359, 32129, 31850, 31521, 31143, 30716,
		30242, 29720, 29151, 28538, 27879, 27177, 26433, 25647, 24821, 23957,
		23055, 22117, 21145, 20139, 19102, 18036, 16941, 15820, 14674, 13505,
		12315, 11106, 9879, 8637, 7381, 6114, 4838, 3554, 2264, 971
	};

endpackage

/* common/macBus.sv */
`timescale 1ns/10ps

interface macBus
	import lpcPkg::*, acfCtrlPkg::*;
();

	// Windowed operand pair y[n] and y[n-k]
	logic signed [sampleW-1:0] opA;
	logic signed [sampleW-1:0] opB;

	// What the accumulator does with them
	macOp_t op;

	// Current lag, tags the emitted result
	logic [lagW-1:0] lag;

	modport buffer (output opA, output opB);

	modport control (output op, output lag);

	modport mac (input opA, input opB, input op, input lag);

endinterface

/* list.f */
common/lpcPkg.sv
common/acfCtrlPkg.sv
common/macBus.sv
window/windowBuffer.sv
rtl/sampleCounter.sv
rtl/acfSequencer.sv
rtl/acfMac.sv
rtl/lpcWindowTop.sv
testbench/acfChecker.sv
testbench/lpcWindowTb.sv

/* rtl/acfMac.sv */
`timescale 1ns/10ps

module acfMac
	import lpcPkg::*, acfCtrlPkg::*;
(
	input  logic                   clk,
	input  logic                   rstN,
	macBus.mac                     mac,
	output logic signed [acfW-1:0] acfOut,
	output logic [lagW-1:0]        acfLag,
	output logic                   acfValid
);

	// Product stage
	logic signed [2*sampleW-1:0] prodQ;
	macOp_t opQ;
	logic [lagW-1:0] lagQ;

	// Accumulate stage
	logic signed [acfW-1:0] acc;
	logic signed [acfW-1:0] prodExt;

	assign prodExt = {{(acfW-2*sampleW){prodQ[2*sampleW-1]}}, prodQ};

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		prodQ <= $signed({{sampleW{mac.opA[sampleW-1]}}, mac.opA})
			* $signed({{sampleW{mac.opB[sampleW-1]}}, mac.opB});
		lagQ <= mac.lag;
		case (opQ)
			opClear: acc <= '0;
			opAccum: acc <= acc + prodExt;
			default: acc <= acc;
		endcase
		// Result and its lag leave together
		if (opQ == opEmit) begin
			acfOut <= acc;
			acfLag <= lagQ;
		end
	end

	// Opcode follows the product register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			opQ <= opIdle;
			acfValid <= 1'b0;
		end else begin
			opQ <= mac.op;
			acfValid <= (opQ == opEmit);
		end
	end

endmodule

/* rtl/acfSequencer.sv */
`timescale 1ns/10ps

module acfSequencer
	import acfCtrlPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  logic   sampleStrobe,
	input  logic   idxLast,
	input  logic   lagLast,
	output logic   countLoad,
	output logic   countStep,
	output logic   lagStep,
	output logic   lagReset,
	output logic   busy,
	output logic   frameDone,
	macBus.control mac
);

	seqState_t state;
	seqState_t stateNext;
	macOp_t opNext;

	// Second drain cycle
	logic drainCnt;

	logic sampleAccept;
	logic loadDone;

	// Strobes while busy are dropped
	assign sampleAccept = sampleStrobe && !busy;

	assign loadDone = (state == sLoad) && sampleAccept && idxLast;

	//////////////////////////////////////////////////////////////////////
	// Next state and counter controls
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		stateNext = state;
		countLoad = 1'b0;
		countStep = 1'b0;
		lagStep = 1'b0;
		lagReset = 1'b0;
		opNext = opIdle;
		case (state)
			sLoad: begin
				if (sampleAccept) begin
					if (idxLast) begin
						// Frame complete, start lag 0
						countLoad = 1'b1;
						opNext = opClear;
						stateNext = sAccum;
					end else begin
						countStep = 1'b1;
					end
				end
			end
			sAccum: begin
				opNext = opAccum;
				if (idxLast) begin
					stateNext = sDrain;
				end else begin
					countStep = 1'b1;
				end
			end
			sDrain: begin
				// Last product is on the bus in the first drain cycle
				if (!drainCnt) begin
					opNext = opEmit;
				end else begin
					stateNext = sEmit;
				end
			end
			sEmit: begin
				countLoad = 1'b1;
				if (lagLast) begin
					lagReset = 1'b1;
					stateNext = sLoad;
				end else begin
					lagStep = 1'b1;
					opNext = opClear;
					stateNext = sAccum;
				end
			end
			default: stateNext = sLoad;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= sLoad;
			mac.op <= opIdle;
			drainCnt <= 1'b0;
			busy <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			state <= stateNext;
			mac.op <= opNext;
			drainCnt <= (state == sDrain) ? !drainCnt : 1'b0;
			// Lines up with the MAC output register
			frameDone <= (state == sEmit) && lagLast;
			if (loadDone) begin
				busy <= 1'b1;
			end else if (frameDone) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

/* rtl/lpcWindowTop.sv */
`timescale 1ns/10ps

module lpcWindowTop
	import lpcPkg::*;
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic signed [sampleW-1:0] sampleIn,
	input  logic                      sampleStrobe,
	output logic                      busy,
	output logic signed [acfW-1:0]    acfOut,
	output logic [lagW-1:0]           acfLag,
	output logic                      acfValid,
	output logic                      frameDone
);

	logic [idxW-1:0] idx;
	logic idxLast;
	logic lagLast;
	logic countLoad;
	logic countStep;
	logic lagStep;
	logic lagReset;

	// Only samples outside a busy window reach the buffer
	logic sampleAccept;

	macBus macIf ();

	assign sampleAccept = sampleStrobe && !busy;

	windowBuffer windowBuffer_i (
		.clk          (clk),
		.rstN         (rstN),
		.sampleIn     (sampleIn),
		.sampleStrobe (sampleAccept),
		.writeIdx     (idx),
		.readIdx      (idx),
		.lag          (macIf.lag),
		.mac          (macIf.buffer)
	);

	sampleCounter sampleCounter_i (
		.clk       (clk),
		.rstN      (rstN),
		.countLoad (countLoad),
		.countStep (countStep),
		.lagStep   (lagStep),
		.lagReset  (lagReset),
		.idx       (idx),
		.lag       (macIf.lag),
		.idxLast   (idxLast),
		.lagLast   (lagLast)
	);

	acfSequencer acfSequencer_i (
		.clk          (clk),
		.rstN         (rstN),
		.sampleStrobe (sampleStrobe),
		.idxLast      (idxLast),
		.lagLast      (lagLast),
		.countLoad    (countLoad),
		.countStep    (countStep),
		.lagStep      (lagStep),
		.lagReset     (lagReset),
		.busy         (busy),
		.frameDone    (frameDone),
		.mac          (macIf.control)
	);

	acfMac acfMac_i (
		.clk      (clk),
		.rstN     (rstN),
		.mac      (macIf.mac),
		.acfOut   (acfOut),
		.acfLag   (acfLag),
		.acfValid (acfValid)
	);

endmodule

/* rtl/sampleCounter.sv */
`timescale 1ns/10ps

module sampleCounter
	import lpcPkg::*;
(
	input  logic            clk,
	input  logic            rstN,
	input  logic            countLoad,
	input  logic            countStep,
	input  logic            lagStep,
	input  logic            lagReset,
	output logic [idxW-1:0] idx,
	output logic [lagW-1:0] lag,
	output logic            idxLast,
	output logic            lagLast
);

	// Lag value after this cycle
	logic [lagW-1:0] lagNext;

	always_comb begin
		lagNext = lag;
		if (lagReset) begin
			lagNext = '0;
		end else if (lagStep) begin
			lagNext = lag + lagW'(1);
		end
	end

	// A lag run starts at n = k
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idx <= '0;
			lag <= '0;
		end else begin
			lag <= lagNext;
			if (countLoad) begin
				idx <= {{(idxW-lagW){1'b0}}, lagNext};
			end else if (countStep) begin
				idx <= idx + idxW'(1);
			end
		end
	end

	assign idxLast = (idx == idxW'(frameLen - 1));

	assign lagLast = (lag == lagW'(numLags - 1));

endmodule

/* testbench/acfChecker.sv */
`timescale 1ns/10ps

module acfChecker
	import lpcPkg::*;
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic signed [sampleW-1:0] sampleIn,
	input  logic                      sampleStrobe,
	input  logic                      busy,
	input  logic signed [acfW-1:0]    acfOut,
	input  logic [lagW-1:0]           acfLag,
	input  logic                      acfValid,
	input  logic                      frameDone,
	input  int                        testId,
	input  logic                      testEnd,
	output int                        testsPassed,
	output int                        testsFailed,
	output int                        errorTotal
);

	// Model frame, windowed on arrival
	longint frame [frameLen];
	int fill;
	logic busyExp;

	// Expected results in arrival order
	int expLag [$];
	longint expVal [$];

	// Counts for the running test
	int errors;
	int checked;
	int framesIn;
	int donePulses;
	int priorErrors;

	int lagWant;
	longint valWant;
	longint valGot;

	assign errorTotal = priorErrors + errors;

	// Q15 multiply by the window tap, rounded, kept to sample width
	function automatic longint windowed(input longint s, input int n);
		longint w;
		longint r;
		w = longint'(hammingWindow[n]);
		r = (s * w + 64'sd16384) >>> 15;
		return longint'($signed(r[sampleW-1:0]));
	endfunction

	task automatic expectFrame();
		longint sum;
		for (int k = 0; k < numLags; k++) begin
			sum = 0;
			for (int n = k; n < frameLen; n++) begin
				sum += frame[n] * frame[n - k];
			end
			expLag.push_back(k);
			expVal.push_back(sum);
		end
	endtask

	initial begin
		fill = 0;
		busyExp = 1'b0;
		errors = 0;
		checked = 0;
		framesIn = 0;
		donePulses = 0;
		priorErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// Model and comparison, sampled on the rising edge
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (!rstN) begin
			fill = 0;
			busyExp = 1'b0;
			expLag.delete();
			expVal.delete();
		end else begin
			if (busy !== busyExp) begin
				$display("Error at %0d ns: busy is %b, expected %b", $time, busy, busyExp);
				errors++;
				// Follow the DUT again so one slip is reported once
				busyExp = busy;
			end
			if (sampleStrobe && !busyExp) begin
				frame[fill] = windowed(longint'(sampleIn), fill);
				fill++;
				if (fill == frameLen) begin
					expectFrame();
					fill = 0;
					framesIn++;
					busyExp = 1'b1;
				end
			end
			if (acfValid) begin
				if (expLag.size() == 0) begin
					$display("Unexpected result for lag %0d at %0d ns with no frame pending",
						acfLag, $time);
					errors++;
				end else begin
					lagWant = expLag.pop_front();
					valWant = expVal.pop_front();
					valGot = longint'(acfOut);
					checked++;
					if (int'(acfLag) != lagWant || valGot != valWant) begin
						$display("Error at %0d ns: lag %0d expected %0d, got lag %0d value %0d",
							$time, lagWant, valWant, acfLag, valGot);
						errors++;
					end
				end
			end
			// frameDone belongs with the last lag only
			if (frameDone) begin
				donePulses++;
				busyExp = 1'b0;
				if (!(acfValid && acfLag == lagW'(numLags - 1))) begin
					$display("frameDone pulsed at %0d ns without the last lag result", $time);
					errors++;
				end
			end else if (acfValid && acfLag == lagW'(numLags - 1)) begin
				$display("Last lag result at %0d ns came without frameDone", $time);
				errors++;
			end
			if (testEnd) begin
				if (expLag.size() != 0) begin
					$display("Test %0d: %0d results never arrived", testId, expLag.size());
					errors++;
					expLag.delete();
					expVal.delete();
				end
				if (donePulses != framesIn) begin
					$display("Test %0d: %0d frames fed but frameDone pulsed %0d times",
						testId, framesIn, donePulses);
					errors++;
				end
				if (errors == 0) begin
					testsPassed++;
					$display("Test %0d passed, %0d results checked", testId, checked);
				end else begin
					testsFailed++;
					$display("Test %0d FAILED, %0d results checked, %0d errors",
						testId, checked, errors);
				end
				priorErrors += errors;
				errors = 0;
				checked = 0;
				framesIn = 0;
				donePulses = 0;
			end
		end
	end

endmodule

/* testbench/lpcWindowTb.sv */
`timescale 1ns/10ps

module lpcWindowTb
	import lpcPkg::*;
();

	// Frames fed over the whole run
	localparam int frameCount = 11;
	localparam int cycleLimit = frameCount * (frameLen * 3 + numLags * 245) * 2;

	logic clk;
	logic rstN;
	logic signed [sampleW-1:0] sampleIn;
	logic sampleStrobe;
	logic busy;
	logic signed [acfW-1:0] acfOut;
	logic [lagW-1:0] acfLag;
	logic acfValid;
	logic frameDone;

	int testId;
	logic testEnd;
	int testsPassed;
	int testsFailed;
	int errorTotal;
	int cycleCount;

	lpcWindowTop dut_i (
		.clk          (clk),
		.rstN         (rstN),
		.sampleIn     (sampleIn),
		.sampleStrobe (sampleStrobe),
		.busy         (busy),
		.acfOut       (acfOut),
		.acfLag       (acfLag),
		.acfValid     (acfValid),
		.frameDone    (frameDone)
	);

	acfChecker checker_i (
		.clk          (clk),
		.rstN         (rstN),
		.sampleIn     (sampleIn),
		.sampleStrobe (sampleStrobe),
		.busy         (busy),
		.acfOut       (acfOut),
		.acfLag       (acfLag),
		.acfValid     (acfValid),
		.frameDone    (frameDone),
		.testId       (testId),
		.testEnd      (testEnd),
		.testsPassed  (testsPassed),
		.testsFailed  (testsFailed),
		.errorTotal   (errorTotal)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, the DUT stopped delivering results", cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////
	// Up to gapMax idle cycles, then one strobe
	task automatic driveSample(input logic signed [sampleW-1:0] value, input int gapMax);
		int gap;
		gap = $urandom_range(gapMax, 0);
		repeat (gap) begin
			@(posedge clk);
			#1;
			sampleStrobe = 1'b0;
		end
		@(posedge clk);
		#1;
		sampleStrobe = 1'b1;
		sampleIn = value;
	endtask

	task automatic randomFrame(input int gapMax);
		for (int n = 0; n < frameLen; n++) begin
			driveSample(sampleW'($urandom), gapMax);
		end
	endtask

	task automatic patternFrame(input logic signed [sampleW-1:0] evenVal,
		input logic signed [sampleW-1:0] oddVal);
		for (int n = 0; n < frameLen; n++) begin
			driveSample((n % 2 == 0) ? evenVal : oddVal, 1);
		end
	endtask

	// Returns in the frameDone cycle
	task automatic waitForFrame();
		do begin
			@(posedge clk);
			#1;
			sampleStrobe = 1'b0;
		end while (!frameDone);
	endtask

	// Random strobes that land only while busy is high
	task automatic strobeDuringBusy();
		do begin
			@(posedge clk);
			#1;
			sampleStrobe = 1'($urandom_range(1, 0));
			sampleIn = sampleW'($urandom);
		end while (!frameDone);
	endtask

	task automatic closeTest();
		@(posedge clk);
		#1;
		sampleStrobe = 1'b0;
		testEnd = 1'b1;
		@(posedge clk);
		#1;
		testEnd = 1'b0;
		testId++;
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		sampleIn = '0;
		sampleStrobe = 1'b0;
		testEnd = 1'b0;
		testId = 1;
		cycleCount = 0;
		void'($urandom(30518));
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Idle, then one sample short of a frame
		repeat (16) @(posedge clk);
		for (int n = 0; n < frameLen - 1; n++) begin
			driveSample(sampleW'($urandom), 2);
		end
		closeTest();

		// Finish that frame, then a fresh random one
		driveSample(sampleW'($urandom), 2);
		waitForFrame();
		randomFrame(2);
		waitForFrame();
		closeTest();

		// Extremes for rounding and accumulator range
		patternFrame(16'sh8000, 16'sh8000);
		waitForFrame();
		patternFrame(16'sh7fff, 16'sh7fff);
		waitForFrame();
		patternFrame(16'sh7fff, 16'sh8000);
		waitForFrame();
		closeTest();

		randomFrame(2);
		strobeDuringBusy();
		randomFrame(2);
		waitForFrame();
		closeTest();

		// Back to back, strobe every cycle
		repeat (4) begin
			randomFrame(0);
			waitForFrame();
		end
		closeTest();

		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			testsPassed, testsFailed, errorTotal);
		if (testsFailed == 0 && errorTotal == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* window/windowBuffer.sv */
`timescale 1ns/10ps

module windowBuffer
	import lpcPkg::*;
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic signed [sampleW-1:0] sampleIn,
	input  logic                      sampleStrobe,
	input  logic [idxW-1:0]           writeIdx,
	input  logic [idxW-1:0]           readIdx,
	input  logic [lagW-1:0]           lag,
	macBus.buffer                     mac
);

	// Windowed frame
	logic signed [sampleW-1:0] frameMem [frameLen];

	logic [sampleW-1:0] winCoef;
	logic signed [2*sampleW-1:0] winProduct;
	logic signed [2*sampleW-1:0] winRounded;
	logic signed [sampleW-1:0] winSample;

	// Write stage
	logic signed [sampleW-1:0] wrData;
	logic [idxW-1:0] wrAddr;
	logic wrValid;

	// Address of the lagged operand
	logic [idxW-1:0] lagIdx;

	//////////////////////////////////////////////////////////////////////
	// Window multiply with Q15 rounding
	//////////////////////////////////////////////////////////////////////
	assign winCoef = hammingWindow[writeIdx];

	// Taps are unsigned, zero extended ahead of the signed multiply
	assign winProduct = $signed({{sampleW{sampleIn[sampleW-1]}}, sampleIn})
		* $signed({{sampleW{1'b0}}, winCoef});

	assign winRounded = (winProduct + 32'sd16384) >>> 15;

	assign winSample = winRounded[sampleW-1:0];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrValid <= 1'b0;
		end else begin
			wrValid <= sampleStrobe;
		end
	end

	// Capture the product with its slot
	always_ff @(posedge clk) begin
		if (sampleStrobe) begin
			wrData <= winSample;
			wrAddr <= writeIdx;
		end
	end

	always_ff @(posedge clk) begin
		if (wrValid) begin
			frameMem[wrAddr] <= wrData;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports toward the MAC
	//////////////////////////////////////////////////////////////////////
	assign lagIdx = readIdx - {{(idxW-lagW){1'b0}}, lag};

	// One cycle behind the read address
	always_ff @(posedge clk) begin
		mac.opA <= frameMem[readIdx];
		mac.opB <= frameMem[lagIdx];
	end

endmodule
